//--- edpTop.f
+incdir+.
edpPkg.sv
aluSlice.sv
fastMemory.sv
microControl.sv
dataPath.sv
edpTop.sv
tbEdp.sv

//--- Bender.yml
package:
  name: edp

export_include_dirs:
  - .

sources:
  - edpPkg.sv
  - aluSlice.sv
  - fastMemory.sv
  - microControl.sv
  - dataPath.sv
  - edpTop.sv
  - target: test
    files:
      - tbEdp.sv

//--- tbEdp.sv
`timescale 1ns/100ps
`include "edp_defines.svh"

module tbEdp;

  localparam int diagTimeout = 20;

  logic clk;
  logic reset;
  logic uwValid;
  edpPkg::microWord_t uWord;
  edpPkg::word_t dataIn;
  logic diagReq;
  edpPkg::diagSel_t diagSel;
  edpPkg::aluFlags_t flags;
  logic diagValid;
  edpPkg::word_t diagData;

  // Reference model of the architectural state
  edpPkg::word_t mAr;
  edpPkg::word_t mArx;
  edpPkg::word_t mBr;
  edpPkg::word_t mBrx;
  edpPkg::word_t mMq;
  edpPkg::aluFlags_t mFlags;
  edpPkg::word_t mFm [`EDP_FM_WORDS];
  edpPkg::fmAddr_t mFmAddr;

  int errors;
  int checks;

  edpTop uut (
    .clk(clk),
    .reset(reset),
    .uwValid(uwValid),
    .uWord(uWord),
    .dataIn(dataIn),
    .diagReq(diagReq),
    .diagSel(diagSel),
    .flags(flags),
    .diagValid(diagValid),
    .diagData(diagData)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic edpPkg::word_t randWord();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return edpPkg::word_t'(r);
  endfunction

  // All holds, AD forced to zero
  function automatic edpPkg::microWord_t makeNop();
    edpPkg::microWord_t uw;
    uw = '0;
    uw.aluOp = edpPkg::aluPassA;
    uw.adaSel = edpPkg::adaZero;
    uw.adbSel = edpPkg::adbBR;
    return uw;
  endfunction

  task automatic modelAlu(input edpPkg::aluOp_t op, input edpPkg::word_t a,
                          input edpPkg::word_t b, input logic cin,
                          output edpPkg::word_t r, output logic co, output logic ov);
    logic [36:0] s;
    r = '0;
    co = 1'b0;
    ov = 1'b0;
    case (op)
      edpPkg::aluAdd: begin
        s = {1'b0, a} + {1'b0, b} + 37'(cin);
        r = s[35:0];
        co = s[36];
        ov = (a[35] == b[35]) && (r[35] != a[35]);
      end
      edpPkg::aluSub: begin
        s = {1'b0, a} + {1'b0, ~b} + 37'(cin);
        r = s[35:0];
        co = s[36];
        // Signs differ and the difference flips away from a
        ov = (a[35] != b[35]) && (r[35] != a[35]);
      end
      edpPkg::aluAnd: r = a & b;
      edpPkg::aluOr: r = a | b;
      edpPkg::aluXor: r = a ^ b;
      edpPkg::aluPassA: r = a;
      edpPkg::aluPassB: r = b;
      default: r = ~a;
    endcase
  endtask

  function automatic edpPkg::word_t loadValue(input edpPkg::arSel_t sel,
                                              input edpPkg::word_t cur,
                                              input edpPkg::word_t ad,
                                              input edpPkg::word_t adx,
                                              input edpPkg::word_t data,
                                              input edpPkg::word_t fm);
    case (sel)
      edpPkg::arAD: return ad;
      edpPkg::arADX: return adx;
      edpPkg::arData: return data;
      edpPkg::arFM: return fm;
      default: return cur;
    endcase
  endfunction

  // One microword applied to the model in program order
  task automatic modelExec(input edpPkg::microWord_t uw, input edpPkg::word_t data);
    edpPkg::word_t ada;
    edpPkg::word_t adb;
    edpPkg::word_t adxB;
    edpPkg::word_t ad;
    edpPkg::word_t adx;
    edpPkg::word_t fmWord;
    edpPkg::word_t newAr;
    edpPkg::word_t newArx;
    logic adCarry;
    logic adOver;
    logic adxCarry;
    logic adxOver;
    fmWord = mFm[uw.fmAddr];
    case (uw.adaSel)
      edpPkg::adaAR: ada = mAr;
      edpPkg::adaARX: ada = mArx;
      edpPkg::adaMQ: ada = mMq;
      default: ada = '0;
    endcase
    case (uw.adbSel)
      edpPkg::adbFM: adb = fmWord;
      edpPkg::adbBR: adb = mBr;
      edpPkg::adbBRx2: adb = {mBr[34:0], mBrx[35]};
      default: adb = {27'b0, uw.magic};
    endcase
    adxB = mBrx;
    if (uw.longMode && uw.adbSel == edpPkg::adbBRx2) begin
      adxB = {mBrx[34:0], 1'b0};
    end
    // Low word first so its carry can ripple up
    modelAlu(uw.aluOp, mArx, adxB, uw.carryIn, adx, adxCarry, adxOver);
    modelAlu(uw.aluOp, ada, adb, uw.longMode ? adxCarry : uw.carryIn, ad, adCarry, adOver);
    newAr = loadValue(uw.arSel, mAr, ad, adx, data, fmWord);
    newArx = loadValue(uw.arxSel, mArx, ad, adx, data, fmWord);
    if (uw.fmWriteLeft) begin
      mFm[uw.fmAddr][35:18] = mAr[35:18];
    end
    if (uw.fmWriteRight) begin
      mFm[uw.fmAddr][17:0] = mAr[17:0];
    end
    if (uw.brLoad) begin
      mBr = mAr;
    end
    if (uw.brxLoad) begin
      mBrx = mArx;
    end
    case (uw.mqOp)
      edpPkg::mqLoad: mMq = ad;
      edpPkg::mqShl: mMq = {mMq[34:0], ad[35]};
      edpPkg::mqShr: mMq = {mMq[35], mMq[35:1]};
      default: mMq = mMq;
    endcase
    mFlags.carryOut = adCarry;
    mFlags.overflow = adOver;
    mFlags.zero = (ad == '0);
    mAr = newAr;
    mArx = newArx;
    mFmAddr = uw.fmAddr;
  endtask

  task automatic compareWord(input string name, input edpPkg::word_t got,
                             input edpPkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic compareFlags(input string name, input edpPkg::aluFlags_t got,
                              input edpPkg::aluFlags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic sendWord(input edpPkg::microWord_t uw, input edpPkg::word_t data);
    @(posedge clk);
    uwValid <= 1'b1;
    uWord <= uw;
    dataIn <= data;
    modelExec(uw, data);
  endtask

  task automatic idle();
    @(posedge clk);
    uwValid <= 1'b0;
  endtask

  task automatic runWord(input edpPkg::microWord_t uw, input edpPkg::word_t data);
    sendWord(uw, data);
    idle();
  endtask

  task automatic setAr(input edpPkg::word_t value);
    edpPkg::microWord_t uw;
    uw = makeNop();
    uw.arSel = edpPkg::arData;
    runWord(uw, value);
  endtask

  task automatic setArx(input edpPkg::word_t value);
    edpPkg::microWord_t uw;
    uw = makeNop();
    uw.arxSel = edpPkg::arData;
    runWord(uw, value);
  endtask

  task automatic copyToB();
    edpPkg::microWord_t uw;
    uw = makeNop();
    uw.brLoad = 1'b1;
    uw.brxLoad = 1'b1;
    runWord(uw, '0);
  endtask

  // Returns at a falling edge so results are settled
  task automatic readDiag(input edpPkg::diagSel_t sel, output edpPkg::word_t value);
    int waitCount;
    @(posedge clk);
    diagReq <= 1'b1;
    diagSel <= sel;
    @(posedge clk);
    diagReq <= 1'b0;
    waitCount = 0;
    do begin
      @(negedge clk);
      waitCount++;
    end while (!diagValid && waitCount < diagTimeout);
    if (!diagValid) begin
      errors++;
      $display("diagnostic readback of %s never returned valid", sel.name());
      value = 'x;
    end else begin
      value = diagData;
    end
  endtask

  task automatic verifyRegister(input edpPkg::diagSel_t sel, input string name,
                                input edpPkg::word_t exp);
    edpPkg::word_t got;
    readDiag(sel, got);
    compareWord(name, got, exp);
  endtask

  task automatic verifyAllRegisters();
    verifyRegister(edpPkg::dgAR, "AR", mAr);
    verifyRegister(edpPkg::dgARX, "ARX", mArx);
    verifyRegister(edpPkg::dgBR, "BR", mBr);
    verifyRegister(edpPkg::dgBRX, "BRX", mBrx);
    verifyRegister(edpPkg::dgMQ, "MQ", mMq);
  endtask

  task automatic loadAndReadBack();
    // Model is all zero here, matching the reset state
    verifyAllRegisters();
    setAr(randWord());
    setArx(randWord());
    copyToB();
    setAr(randWord());
    setArx(randWord());
    verifyAllRegisters();
  endtask

  task automatic aluCase(input edpPkg::aluOp_t op, input edpPkg::word_t a,
                         input edpPkg::word_t b);
    edpPkg::microWord_t uw;
    setAr(b);
    copyToB();
    setAr(a);
    uw = makeNop();
    uw.aluOp = op;
    uw.adaSel = edpPkg::adaAR;
    uw.adbSel = edpPkg::adbBR;
    uw.arSel = edpPkg::arAD;
    uw.carryIn = (op == edpPkg::aluSub);
    runWord(uw, '0);
    verifyRegister(edpPkg::dgAR, "AR", mAr);
    compareFlags("flags", flags, mFlags);
  endtask

  task automatic shortAluOps();
    edpPkg::microWord_t uw;
    edpPkg::word_t same;
    for (int i = 0; i < 8; i++) begin
      aluCase(edpPkg::aluOp_t'(i), randWord(), randWord());
    end
    same = randWord();
    // Overflow, carry and zero corners
    aluCase(edpPkg::aluAdd, 36'h7_FFFF_FFFF, 36'h1);
    aluCase(edpPkg::aluAdd, 36'hF_FFFF_FFFF, 36'h1);
    aluCase(edpPkg::aluSub, 36'h8_0000_0000, 36'h1);
    aluCase(edpPkg::aluSub, same, same);
    aluCase(edpPkg::aluXor, same, same);
    uw = makeNop();
    uw.aluOp = edpPkg::aluAdd;
    uw.adaSel = edpPkg::adaAR;
    uw.adbSel = edpPkg::adbMagic;
    uw.magic = 9'h1a5;
    uw.arSel = edpPkg::arAD;
    runWord(uw, '0);
    verifyRegister(edpPkg::dgAR, "AR", mAr);
    compareFlags("flags", flags, mFlags);
  endtask

  task automatic longCase(input edpPkg::word_t ah, input edpPkg::word_t al,
                          input edpPkg::word_t bh, input edpPkg::word_t bl,
                          input logic sub, input logic dbl);
    edpPkg::microWord_t uw;
    logic [71:0] sum72;
    setAr(bh);
    setArx(bl);
    copyToB();
    setAr(ah);
    setArx(al);
    uw = makeNop();
    uw.aluOp = sub ? edpPkg::aluSub : edpPkg::aluAdd;
    uw.adaSel = edpPkg::adaAR;
    uw.adbSel = dbl ? edpPkg::adbBRx2 : edpPkg::adbBR;
    uw.arSel = edpPkg::arAD;
    uw.arxSel = edpPkg::arADX;
    uw.carryIn = sub;
    uw.longMode = 1'b1;
    runWord(uw, '0);
    // Plain 72-bit arithmetic on the register pairs
    if (sub) begin
      sum72 = {ah, al} - {bh, bl};
    end else begin
      sum72 = {ah, al} + ({bh, bl} << dbl);
    end
    verifyRegister(edpPkg::dgAR, "AR", sum72[71:36]);
    verifyRegister(edpPkg::dgARX, "ARX", sum72[35:0]);
    compareFlags("flags", flags, mFlags);
  endtask

  task automatic longArithmetic();
    longCase(randWord(), 36'hF_FFFF_FFFF, randWord(), 36'h1, 1'b0, 1'b0);
    longCase(36'hF_FFFF_FFFF, 36'hF_FFFF_FFFF, 36'h0, 36'h1, 1'b0, 1'b0);
    longCase(randWord(), randWord(), randWord(), randWord(), 1'b0, 1'b0);
    longCase(randWord(), randWord(), randWord(), randWord(), 1'b1, 1'b0);
    longCase(randWord(), randWord(), randWord(), randWord(), 1'b0, 1'b1);
  endtask

  task automatic mqStep(input edpPkg::mqOp_t op, input edpPkg::word_t arValue);
    edpPkg::microWord_t uw;
    setAr(arValue);
    uw = makeNop();
    uw.adaSel = edpPkg::adaAR;
    uw.mqOp = op;
    runWord(uw, '0);
    verifyRegister(edpPkg::dgMQ, "MQ", mMq);
  endtask

  task automatic mqShifting();
    edpPkg::word_t w;
    mqStep(edpPkg::mqLoad, 36'h8_0123_4567);
    repeat (3) mqStep(edpPkg::mqShr, randWord());
    mqStep(edpPkg::mqLoad, 36'h1_2345_6789);
    repeat (2) mqStep(edpPkg::mqShr, randWord());
    // Left shift fill alternates with the AR sign
    for (int i = 0; i < 6; i++) begin
      w = randWord();
      w[35] = i[0];
      mqStep(edpPkg::mqShl, w);
    end
  endtask

  task automatic fmStore(input edpPkg::fmAddr_t addr, input logic left, input logic right);
    edpPkg::microWord_t uw;
    uw = makeNop();
    uw.fmAddr = addr;
    uw.fmWriteLeft = left;
    uw.fmWriteRight = right;
    runWord(uw, '0);
  endtask

  task automatic fmHalfwords();
    edpPkg::microWord_t uw;
    edpPkg::fmAddr_t addr;
    for (int k = 0; k < 4; k++) begin
      addr = edpPkg::fmAddr_t'(k * 5 + 3);
      setAr(randWord());
      fmStore(addr, 1'b1, 1'b1);
    end
    setAr(randWord());
    fmStore(4'd3, 1'b1, 1'b0);
    setAr(randWord());
    fmStore(4'd8, 1'b0, 1'b1);
    setAr(randWord());
    fmStore(4'd13, 1'b1, 1'b0);
    fmStore(4'd2, 1'b0, 1'b1);
    for (int k = 0; k < 4; k++) begin
      addr = edpPkg::fmAddr_t'(k * 5 + 3);
      uw = makeNop();
      uw.arSel = edpPkg::arFM;
      uw.fmAddr = addr;
      runWord(uw, '0);
      verifyRegister(edpPkg::dgAR, "AR", mAr);
      verifyRegister(edpPkg::dgFM, "FM", mFm[addr]);
    end
  endtask

  task automatic backToBack();
    edpPkg::microWord_t uw;
    uw = makeNop();
    uw.arSel = edpPkg::arData;
    sendWord(uw, randWord());
    uw.brLoad = 1'b1;
    sendWord(uw, randWord());
    uw = makeNop();
    uw.aluOp = edpPkg::aluAdd;
    uw.adaSel = edpPkg::adaAR;
    uw.arSel = edpPkg::arAD;
    sendWord(uw, '0);
    uw = makeNop();
    uw.adaSel = edpPkg::adaAR;
    uw.arxSel = edpPkg::arAD;
    uw.mqOp = edpPkg::mqLoad;
    uw.brxLoad = 1'b1;
    sendWord(uw, '0);
    uw = makeNop();
    uw.fmAddr = 4'd5;
    uw.fmWriteLeft = 1'b1;
    uw.fmWriteRight = 1'b1;
    sendWord(uw, '0);
    // Reads the word stored one cycle earlier
    uw = makeNop();
    uw.fmAddr = 4'd5;
    uw.arSel = edpPkg::arData;
    uw.arxSel = edpPkg::arFM;
    sendWord(uw, randWord());
    idle();
    verifyAllRegisters();
    verifyRegister(edpPkg::dgFM, "FM", mFm[mFmAddr]);
    compareFlags("flags", flags, mFlags);
  endtask

  initial begin
    void'($urandom(32'hf963));
    errors = 0;
    checks = 0;
    reset = 1'b1;
    uwValid = 1'b0;
    uWord = '0;
    dataIn = '0;
    diagReq = 1'b0;
    diagSel = edpPkg::dgAR;
    mAr = '0;
    mArx = '0;
    mBr = '0;
    mBrx = '0;
    mMq = '0;
    mFlags = '0;
    mFmAddr = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    loadAndReadBack();
    shortAluOps();
    longArithmetic();
    mqShifting();
    fmHalfwords();
    backToBack();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- edpTop.sv
`timescale 1ns/100ps

module edpTop (
  input logic clk,
  input logic reset,
  input logic uwValid,
  input edpPkg::microWord_t uWord,
  input edpPkg::word_t dataIn,
  input logic diagReq,
  input edpPkg::diagSel_t diagSel,
  output edpPkg::aluFlags_t flags,
  output logic diagValid,
  output edpPkg::word_t diagData
);

  edpPkg::dpControl_t ctl;
  edpPkg::word_t heldData;
  edpPkg::fmAddr_t fmAddr;
  logic fmWriteLeft;
  logic fmWriteRight;
  edpPkg::word_t fmData;
  edpPkg::word_t ar;

  microControl ctrl (
    .clk(clk),
    .reset(reset),
    .uwValid(uwValid),
    .uWord(uWord),
    .dataIn(dataIn),
    .ctl(ctl),
    .heldData(heldData),
    .fmAddr(fmAddr),
    .fmWriteLeft(fmWriteLeft),
    .fmWriteRight(fmWriteRight)
  );

  // AR is the only FM write data source
  fastMemory fm (
    .clk(clk),
    .addr(fmAddr),
    .writeLeft(fmWriteLeft),
    .writeRight(fmWriteRight),
    .din(ar),
    .dout(fmData)
  );

  dataPath dp (
    .clk(clk),
    .reset(reset),
    .ctl(ctl),
    .heldData(heldData),
    .fmData(fmData),
    .diagReq(diagReq),
    .diagSel(diagSel),
    .ar(ar),
    .flags(flags),
    .diagValid(diagValid),
    .diagData(diagData)
  );

endmodule

//--- dataPath.sv
`timescale 1ns/100ps

module dataPath (
  input logic clk,
  input logic reset,
  input edpPkg::dpControl_t ctl,
  input edpPkg::word_t heldData,
  input edpPkg::word_t fmData,
  input logic diagReq,
  input edpPkg::diagSel_t diagSel,
  output edpPkg::word_t ar,
  output edpPkg::aluFlags_t flags,
  output logic diagValid,
  output edpPkg::word_t diagData
);

  localparam int W = $bits(edpPkg::word_t);

  edpPkg::word_t arx;
  edpPkg::word_t br;
  edpPkg::word_t brx;
  edpPkg::word_t mq;
  edpPkg::word_t adaMux;
  edpPkg::word_t adbMux;
  edpPkg::word_t adxB;
  edpPkg::word_t ad;
  edpPkg::word_t adx;
  edpPkg::word_t arNext;
  edpPkg::word_t arxNext;
  logic adCarryIn;
  logic adCarryOut;
  logic adOverflow;
  logic adxCarryOut;

  edpPkg::word_t diagSrc [8];
  logic [7:0] srcEn;
  edpPkg::word_t diagMux;
  edpPkg::word_t diagCapture;
  logic diagPending;

  function automatic edpPkg::word_t selectLoad(input edpPkg::arSel_t sel,
                                               input edpPkg::word_t current,
                                               input edpPkg::word_t adRes,
                                               input edpPkg::word_t adxRes,
                                               input edpPkg::word_t data,
                                               input edpPkg::word_t fm);
    case (sel)
      edpPkg::arAD: selectLoad = adRes;
      edpPkg::arADX: selectLoad = adxRes;
      edpPkg::arData: selectLoad = data;
      edpPkg::arFM: selectLoad = fm;
      default: selectLoad = current;
    endcase
  endfunction

  always_comb begin
    unique case (ctl.adaSel)
      edpPkg::adaAR: adaMux = ar;
      edpPkg::adaARX: adaMux = arx;
      edpPkg::adaMQ: adaMux = mq;
      default: adaMux = '0;
    endcase
  end

  // BR times two borrows the top bit of BRX
  always_comb begin
    unique case (ctl.adbSel)
      edpPkg::adbFM: adbMux = fmData;
      edpPkg::adbBR: adbMux = br;
      edpPkg::adbBRx2: adbMux = {br[W-2:0], brx[W-1]};
      default: adbMux = {{(W-9){1'b0}}, ctl.magic};
    endcase
  end

  // Double-length shift of BR:BRX in long mode
  assign adxB = (ctl.longMode && ctl.adbSel == edpPkg::adbBRx2) ? {brx[W-2:0], 1'b0} : brx;

  // ADX is the low word and feeds its carry up into AD
  assign adCarryIn = ctl.longMode ? adxCarryOut : ctl.carryIn;

  aluSlice adAlu (
    .op(ctl.aluOp),
    .a(adaMux),
    .b(adbMux),
    .carryIn(adCarryIn),
    .result(ad),
    .carryOut(adCarryOut),
    .overflow(adOverflow)
  );

  aluSlice adxAlu (
    .op(ctl.aluOp),
    .a(arx),
    .b(adxB),
    .carryIn(ctl.carryIn),
    .result(adx),
    .carryOut(adxCarryOut),
    .overflow()
  );

  assign arNext = selectLoad(ctl.arSel, ar, ad, adx, heldData, fmData);
  assign arxNext = selectLoad(ctl.arxSel, arx, ad, adx, heldData, fmData);

  always_ff @(posedge clk) begin
    if (reset) begin
      ar <= '0;
      arx <= '0;
      br <= '0;
      brx <= '0;
      mq <= '0;
      flags <= '0;
    end else if (ctl.exec) begin
      ar <= arNext;
      arx <= arxNext;
      if (ctl.brLoad) begin
        br <= ar;
      end
      if (ctl.brxLoad) begin
        brx <= arx;
      end
      // MQ as a universal shift register
      unique case (ctl.mqOp)
        edpPkg::mqLoad: mq <= ad;
        edpPkg::mqShl: mq <= {mq[W-2:0], ad[W-1]};
        edpPkg::mqShr: mq <= {mq[W-1], mq[W-1:1]};
        default: mq <= mq;
      endcase
      flags <= '{carryOut: adCarryOut, overflow: adOverflow, zero: (ad == '0)};
    end
  end

  always_comb begin
    diagSrc[edpPkg::dgAR] = ar;
    diagSrc[edpPkg::dgARX] = arx;
    diagSrc[edpPkg::dgBR] = br;
    diagSrc[edpPkg::dgBRX] = brx;
    diagSrc[edpPkg::dgMQ] = mq;
    diagSrc[edpPkg::dgFM] = fmData;
    diagSrc[edpPkg::dgAD] = ad;
    diagSrc[edpPkg::dgADX] = adx;
  end

  // Readback sources are wire-ORed like a shared bus
  assign srcEn = diagReq ? (8'b1 << diagSel) : 8'b0;

  always_comb begin
    diagMux = '0;
    for (int i = 0; i < 8; i++) begin
      if (srcEn[i]) begin
        diagMux = diagMux | diagSrc[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      diagPending <= 1'b0;
      diagValid <= 1'b0;
    end else begin
      diagPending <= diagReq;
      diagValid <= diagPending;
    end
  end

  // Snapshot on the request edge and present it one cycle later
  always_ff @(posedge clk) begin
    if (diagReq) begin
      diagCapture <= diagMux;
    end
    if (diagPending) begin
      diagData <= diagCapture;
    end
  end

  // An unknown select would drive several sources onto the bus at once
  assert property (@(posedge clk) disable iff (reset) diagReq |-> !$isunknown(diagSel))
    else $error("unknown diagnostic select on a readback request");

endmodule

//--- microControl.sv
`timescale 1ns/100ps

module microControl (
  input logic clk,
  input logic reset,
  input logic uwValid,
  input edpPkg::microWord_t uWord,
  input edpPkg::word_t dataIn,
  output edpPkg::dpControl_t ctl,
  output edpPkg::word_t heldData,
  output edpPkg::fmAddr_t fmAddr,
  output logic fmWriteLeft,
  output logic fmWriteRight
);

  logic execReg;
  edpPkg::microWord_t uwReg;

  // Valid only for the cycle after a strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      execReg <= 1'b0;
    end else begin
      execReg <= uwValid;
    end
  end

  always_ff @(posedge clk) begin
    if (uwValid) begin
      uwReg <= uWord;
      heldData <= dataIn;
    end
  end

  always_comb begin
    ctl = '{exec: execReg,
            aluOp: uwReg.aluOp,
            adaSel: uwReg.adaSel,
            adbSel: uwReg.adbSel,
            arSel: uwReg.arSel,
            arxSel: uwReg.arxSel,
            mqOp: uwReg.mqOp,
            brLoad: uwReg.brLoad,
            brxLoad: uwReg.brxLoad,
            magic: uwReg.magic,
            carryIn: uwReg.carryIn,
            longMode: uwReg.longMode};
  end

  // FM stores happen at the end of the executing cycle
  assign fmAddr = uwReg.fmAddr;
  assign fmWriteLeft = execReg && uwReg.fmWriteLeft;
  assign fmWriteRight = execReg && uwReg.fmWriteRight;

  assert property (@(posedge clk) disable iff (reset)
    uwValid |-> !$isunknown(uWord))
    else $error("microword has unknown bits on strobe");

  // Long mode chains carries so only add and subtract make sense
  assert property (@(posedge clk) disable iff (reset)
    ctl.exec && ctl.longMode |-> ctl.aluOp inside {edpPkg::aluAdd, edpPkg::aluSub})
    else $error("long mode with a boolean ALU function");

endmodule

//--- fastMemory.sv
`timescale 1ns/100ps
`include "edp_defines.svh"

module fastMemory #(
  parameter int depth = `EDP_FM_WORDS
) (
  input logic clk,
  input edpPkg::fmAddr_t addr,
  input logic writeLeft,
  input logic writeRight,
  input edpPkg::word_t din,
  output edpPkg::word_t dout
);

  localparam int half = $bits(edpPkg::word_t) / 2;

  edpPkg::word_t mem [depth];

  // Each half has its own enable so halfword stores keep the other half
  always_ff @(posedge clk) begin
    if (writeLeft) begin
      mem[addr][2*half-1:half] <= din[2*half-1:half];
    end
    if (writeRight) begin
      mem[addr][half-1:0] <= din[half-1:0];
    end
  end

  // Read is asynchronous
  assign dout = mem[addr];

endmodule

//--- aluSlice.sv
`timescale 1ns/100ps

module aluSlice (
  input edpPkg::aluOp_t op,
  input edpPkg::word_t a,
  input edpPkg::word_t b,
  input logic carryIn,
  output edpPkg::word_t result,
  output logic carryOut,
  output logic overflow
);

  localparam int W = $bits(edpPkg::word_t);

  logic subtract;
  edpPkg::word_t bOperand;
  logic [W:0] sum;
  logic sumOverflow;

  // Subtract is a + ~b + carryIn
  assign subtract = (op == edpPkg::aluSub);
  assign bOperand = subtract ? ~b : b;

  assign sum = {1'b0, a} + {1'b0, bOperand} + {{W{1'b0}}, carryIn};

  // Operands agree in sign but the sum does not
  assign sumOverflow = (a[W-1] == bOperand[W-1]) && (sum[W-1] != a[W-1]);

  always_comb begin
    result = '0;
    carryOut = 1'b0;
    overflow = 1'b0;
    unique case (op)
      edpPkg::aluAdd,
      edpPkg::aluSub: begin
        result = sum[W-1:0];
        carryOut = sum[W];
        overflow = sumOverflow;
      end
      edpPkg::aluAnd: begin
        result = a & b;
      end
      edpPkg::aluOr: begin
        result = a | b;
      end
      edpPkg::aluXor: begin
        result = a ^ b;
      end
      edpPkg::aluPassA: begin
        result = a;
      end
      edpPkg::aluPassB: begin
        result = b;
      end
      edpPkg::aluNotA: begin
        result = ~a;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- edpPkg.sv
`include "edp_defines.svh"

package edpPkg;

  // One machine word, MSB is the sign
  typedef logic [`EDP_WORD_BITS-1:0] word_t;

  typedef logic [`EDP_FM_ADDR_BITS-1:0] fmAddr_t;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluPassA,
    aluPassB,
    aluNotA
  } aluOp_t;

  // AD A operand
  typedef enum logic [1:0] {adaAR, adaARX, adaMQ, adaZero} adaSel_t;

  // AD B operand
  typedef enum logic [1:0] {adbFM, adbBR, adbBRx2, adbMagic} adbSel_t;

  // Load source for AR and ARX
  typedef enum logic [2:0] {arHold, arAD, arADX, arData, arFM} arSel_t;

  // MQ universal shift register functions
  typedef enum logic [1:0] {mqHold, mqLoad, mqShl, mqShr} mqOp_t;

  typedef enum logic [2:0] {dgAR, dgARX, dgBR, dgBRX, dgMQ, dgFM, dgAD, dgADX} diagSel_t;

  typedef struct packed {
    aluOp_t aluOp;
    adaSel_t adaSel;
    adbSel_t adbSel;
    arSel_t arSel;
    arSel_t arxSel;
    mqOp_t mqOp;
    logic brLoad;
    logic brxLoad;
    logic fmWriteLeft;
    logic fmWriteRight;
    fmAddr_t fmAddr;
    logic [8:0] magic;
    logic carryIn;
    logic longMode;
  } microWord_t;

  // Registered data path steering, fast memory fields go straight to FM
  typedef struct packed {
    logic exec;
    aluOp_t aluOp;
    adaSel_t adaSel;
    adbSel_t adbSel;
    arSel_t arSel;
    arSel_t arxSel;
    mqOp_t mqOp;
    logic brLoad;
    logic brxLoad;
    logic [8:0] magic;
    logic carryIn;
    logic longMode;
  } dpControl_t;

  typedef struct packed {
    logic carryOut;
    logic overflow;
    logic zero;
  } aluFlags_t;

endpackage

//--- edp_defines.svh
`ifndef EDP_DEFINES_SVH
`define EDP_DEFINES_SVH

// Data word width with bit 35 as the sign
`define EDP_WORD_BITS 36

// Fast memory geometry
`define EDP_FM_WORDS 16
`define EDP_FM_ADDR_BITS 4

`endif
